// ==== flist.f ====
rtl/fgen_pkg.sv
rtl/pkt_sequencer.sv
rtl/byte_fetch.sv
rtl/csum_insert.sv
rtl/frame_generator.sv
test/frame_generator_chk.sv
test/tb_frame_generator.sv

// ==== Makefile ====
# Verilator flow for the frame generator

VERILATOR ?= verilator
TOP ?= tb_frame_generator
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
LINT_FLAGS ?= -Wall
SIM_FLAGS ?= --binary --timing --assert -j 0
ERR_LIMIT ?= 1000
PASS_MSG ?= All tests passed!

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

# the run passes only when the pass message shows up in the output
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERR_LIMIT))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/tb_frame_generator.sv ====
module tb_frame_generator;
	import fgen_pkg::*;

	// mirrors of the DUT defaults
	localparam int CMD_PKTS = 2;
	localparam int VIDEO_PKTS = 3;
	localparam int PKTS_PER_FRAME = 1 + CMD_PKTS + VIDEO_PKTS;
	// the third sync packet closes the second full frame
	localparam int SYNC_END = 3;
	localparam int PKTS_END = (SYNC_END - 1) * PKTS_PER_FRAME + 1;
	localparam int RUN_LIMIT = 2000;

	logic clk;
	logic c_done;
	logic [9:0] ram_ra;
	byte_t ram_rd;
	byte_t rxd;
	logic rxen;
	logic pac_stp;
	logic ovp;
	logic [9:0] ra_q;
	int err_cnt;
	int pkt_cnt;
	int sync_cnt;
	int cycles;

	bind frame_generator frame_generator_chk #(
		.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH),
		.PKT_IFG(PKT_IFG),
		.FRAME_IFG(FRAME_IFG),
		.CMD_PKTS(CMD_PKTS),
		.VIDEO_PKTS(VIDEO_PKTS),
		.CMD_LEN(CMD_LEN),
		.VIDEO_LEN(VIDEO_LEN),
		.LINE_LEN(LINE_LEN),
		.FIX_OFFSET(FIX_OFFSET),
		.FIX_VALUE(FIX_VALUE)
	) i_chk (
		.clk(clk),
		.c_done(c_done),
		.rxd(rxd),
		.rxen(rxen),
		.pac_stp(pac_stp),
		.ovp(ovp)
	);

	frame_generator i_dut (
		.clk(clk),
		.c_done(c_done),
		.ram_ra(ram_ra),
		.ram_rd(ram_rd),
		.rxd(rxd),
		.rxen(rxen),
		.pac_stp(pac_stp),
		.ovp(ovp)
	);

	// same fill as the checker expects
	function automatic byte_t ram_pattern(input logic [9:0] a);
		return byte_t'(a) ^ byte_t'(a >> 8) ^ 8'ha5;
	endfunction

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// synchronous RAM, address taken on the rising edge
	always @(posedge clk) begin
		ra_q <= ram_ra;
	end

	// read data goes out on the falling edge, one cycle of latency
	initial begin
		ram_rd = '0;
		forever begin
			@(negedge clk);
			ram_rd = ram_pattern(ra_q);
		end
	end

	initial begin
		c_done = 1'b0;
		err_cnt = 0;
		pkt_cnt = 0;
		sync_cnt = 0;
		cycles = 0;
		repeat (5) @(negedge clk);
		c_done = 1'b1;
		// count packet starts until two whole frames have gone by
		while (sync_cnt < SYNC_END && cycles < RUN_LIMIT) begin
			@(negedge clk);
			cycles++;
			if (pac_stp) begin
				pkt_cnt++;
			end
			if (ovp) begin
				sync_cnt++;
			end
		end
		if (sync_cnt < SYNC_END) begin
			err_cnt++;
			$display("timeout: only %0d frame starts seen in %0d cycles", sync_cnt, cycles);
		end
		if (pkt_cnt < PKTS_END) begin
			err_cnt++;
			$display("too few packets: saw %0d, expected %0d", pkt_cnt, PKTS_END);
		end
		$display("testbench errors: %0d, assertion errors: %0d", err_cnt, i_dut.i_chk.fail_cnt);
		if (err_cnt == 0 && i_dut.i_chk.fail_cnt == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== test/frame_generator_chk.sv ====
module frame_generator_chk #(
	parameter int RAM_ADDR_WIDTH = 10,
	parameter int PKT_IFG = 4,
	parameter int FRAME_IFG = 40,
	parameter int CMD_PKTS = 2,
	parameter int VIDEO_PKTS = 3,
	parameter int CMD_LEN = 16,
	parameter int VIDEO_LEN = 24,
	parameter int LINE_LEN = 20,
	parameter int FIX_OFFSET = 7,
	parameter fgen_pkg::byte_t FIX_VALUE = 8'h01
) (
	input logic clk,
	input logic c_done,
	input fgen_pkg::byte_t rxd,
	input logic rxen,
	input logic pac_stp,
	input logic ovp
);
	import fgen_pkg::*;

	localparam int LAST_PKT = CMD_PKTS + VIDEO_PKTS;
	// header starts after 4 preamble bytes, data after 4 header bytes
	localparam int HDR_START = 4;
	localparam int DATA_START = 8;

	// failed assertions, read by the testbench at the end of the run
	int fail_cnt = 0;

	int pos_q;
	int pkt_q;
	int gap_q;
	logic started;
	logic [RAM_ADDR_WIDTH-1:0] addr_q;
	logic [15:0] sum_q;
	int cur_pos;
	int cur_pkt;
	int data_len;
	int pkt_len;
	int doff;
	logic wrap;
	logic active;
	logic in_pre;
	logic in_hdr;
	logic in_data;
	logic rd_byte;
	byte_t exp_byte;

	// RAM fill, mixes the upper address bits into the low byte
	function automatic byte_t ram_pattern(input logic [RAM_ADDR_WIDTH-1:0] a);
		return byte_t'(a) ^ byte_t'(a >> 8) ^ 8'ha5;
	endfunction

	always_comb begin
		// count wraps to 0 after the last video packet
		wrap = (pkt_q == LAST_PKT);
		cur_pos = pac_stp ? 0 : pos_q;
		if (!pac_stp) begin
			cur_pkt = pkt_q;
		end else if (wrap) begin
			cur_pkt = 0;
		end else begin
			cur_pkt = pkt_q + 1;
		end
		data_len = (cur_pkt > CMD_PKTS) ? VIDEO_LEN : CMD_LEN;
		pkt_len = DATA_START + data_len + 4;
		active = pac_stp || (started && pos_q < pkt_len);
		doff = cur_pos - DATA_START;
		in_pre = (cur_pos < HDR_START);
		in_hdr = !in_pre && (doff < 0);
		in_data = (doff >= 0) && (doff < data_len);
		// sync data is never read, video reads stop at the line length
		rd_byte = in_data && (cur_pkt != 0) && ((cur_pkt <= CMD_PKTS) || (doff < LINE_LEN));
		if (in_pre) begin
			exp_byte = (cur_pos == HDR_START - 1) ? 8'hd5 : 8'h55;
		end else if (in_hdr) begin
			case (cur_pos - HDR_START)
				0: exp_byte = byte_t'(cur_pkt);
				1: exp_byte = byte_t'(cur_pkt >> 8);
				default: exp_byte = '0;
			endcase
		end else if (in_data) begin
			if (cur_pkt == 1 && doff == FIX_OFFSET) begin
				exp_byte = FIX_VALUE;
			end else if (rd_byte) begin
				exp_byte = ram_pattern(addr_q);
			end else begin
				exp_byte = '0;
			end
		end else begin
			// trailer, checksum low then high, then two zeros
			case (doff - data_len)
				0: exp_byte = sum_q[7:0];
				1: exp_byte = sum_q[15:8];
				default: exp_byte = '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge c_done) begin
		if (!c_done) begin
			pos_q <= 0;
			pkt_q <= LAST_PKT;
			gap_q <= 0;
			started <= 1'b0;
			addr_q <= '0;
			sum_q <= '0;
		end else begin
			if (rxen) begin
				pos_q <= cur_pos + 1;
			end
			pkt_q <= cur_pkt;
			gap_q <= rxen ? 0 : gap_q + 1;
			if (pac_stp) begin
				started <= 1'b1;
			end
			// address restarts with each frame-sync packet
			// the fixed byte still uses up its address
			if (pac_stp && wrap) begin
				addr_q <= '0;
			end else if (rxen && rd_byte) begin
				addr_q <= addr_q + 1'b1;
			end
			if (pac_stp) begin
				sum_q <= '0;
			end else if (rxen && (in_hdr || in_data)) begin
				sum_q <= sum_q + 16'(exp_byte);
			end
		end
	end

	a_preamble: assert property (@(posedge clk) disable iff (!c_done)
		(pac_stp || (rxen && in_pre)) |-> (rxen && rxd == exp_byte))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("Fail at %0t: preamble byte %h, expected %h", $time, rxd, exp_byte);
		end

	a_header: assert property (@(posedge clk) disable iff (!c_done)
		(rxen && in_hdr) |-> (rxd == exp_byte))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("Fail at %0t: header byte %h, expected %h", $time, rxd, exp_byte);
		end

	a_data: assert property (@(posedge clk) disable iff (!c_done)
		(rxen && in_data) |-> (rxd == exp_byte))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("Fail at %0t: data byte %h, expected %h", $time, rxd, exp_byte);
		end

	a_trailer: assert property (@(posedge clk) disable iff (!c_done)
		(rxen && !in_pre && !in_hdr && !in_data) |-> (rxd == exp_byte))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("Fail at %0t: trailer byte %h, expected %h", $time, rxd, exp_byte);
		end

	// rxen high for exactly one packet length
	a_length: assert property (@(posedge clk) disable iff (!c_done)
		rxen == active)
		else begin
			fail_cnt = fail_cnt + 1;
			$error("Fail at %0t: rxen %b, expected %b", $time, rxen, active);
		end

	a_sync: assert property (@(posedge clk) disable iff (!c_done)
		(pac_stp || ovp) |-> (pac_stp && ovp == wrap))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("Fail at %0t: ovp %b with pac_stp %b, expected %b", $time, ovp, pac_stp, wrap);
		end

	a_gap: assert property (@(posedge clk) disable iff (!c_done)
		pac_stp |-> (gap_q >= (ovp ? FRAME_IFG : PKT_IFG)))
		else begin
			fail_cnt = fail_cnt + 1;
			$error("Fail at %0t: gap of %0d idle cycles too short", $time, gap_q);
		end

endmodule

// ==== rtl/frame_generator.sv ====
module frame_generator #(
	parameter int RAM_ADDR_WIDTH = 10,
	parameter int PKT_IFG = 4,
	parameter int FRAME_IFG = 40,
	parameter int CMD_PKTS = 2,
	parameter int VIDEO_PKTS = 3,
	parameter int CMD_LEN = 16,
	parameter int VIDEO_LEN = 24,
	parameter int LINE_LEN = 20,
	parameter int FIX_OFFSET = 7,
	parameter fgen_pkg::byte_t FIX_VALUE = 8'h01
) (
	input logic clk,
	input logic c_done,
	output logic [RAM_ADDR_WIDTH-1:0] ram_ra,
	input fgen_pkg::byte_t ram_rd,
	output fgen_pkg::byte_t rxd,
	output logic rxen,
	output logic pac_stp,
	output logic ovp
);
	import fgen_pkg::*;

	// slot out of the FSM, then aligned with its byte
	slot_t seq_slot;
	slot_t fetch_slot;
	byte_t fetch_byte;

	// stage 1, packet framing and counters
	pkt_sequencer #(
		.PKT_IFG(PKT_IFG),
		.FRAME_IFG(FRAME_IFG),
		.CMD_PKTS(CMD_PKTS),
		.VIDEO_PKTS(VIDEO_PKTS),
		.CMD_LEN(CMD_LEN),
		.VIDEO_LEN(VIDEO_LEN),
		.LINE_LEN(LINE_LEN)
	) i_pkt_sequencer (
		.clk(clk),
		.c_done(c_done),
		.seq_slot(seq_slot)
	);

	// stage 2, RAM read and byte selection
	byte_fetch #(
		.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH),
		.FIX_OFFSET(FIX_OFFSET),
		.FIX_VALUE(FIX_VALUE)
	) i_byte_fetch (
		.clk(clk),
		.c_done(c_done),
		.seq_slot(seq_slot),
		.ram_ra(ram_ra),
		.ram_rd(ram_rd),
		.fetch_slot(fetch_slot),
		.fetch_byte(fetch_byte)
	);

	// stage 3, checksum trailer and output registers
	csum_insert i_csum_insert (
		.clk(clk),
		.c_done(c_done),
		.fetch_slot(fetch_slot),
		.fetch_byte(fetch_byte),
		.rxd(rxd),
		.rxen(rxen),
		.pac_stp(pac_stp),
		.ovp(ovp)
	);

endmodule

// ==== rtl/csum_insert.sv ====
module csum_insert (
	input logic clk,
	input logic c_done,
	input fgen_pkg::slot_t fetch_slot,
	input fgen_pkg::byte_t fetch_byte,
	output fgen_pkg::byte_t rxd,
	output logic rxen,
	output logic pac_stp,
	output logic ovp
);
	import fgen_pkg::*;

	logic [15:0] sum;
	logic pkt_start;
	logic sum_en;
	byte_t out_byte;

	// first preamble byte of any packet
	assign pkt_start = fetch_slot.en && (fetch_slot.phase == PH_PRE) &&
		(fetch_slot.pos == '0);

	// header and data bytes count towards the checksum
	assign sum_en = fetch_slot.en &&
		((fetch_slot.phase == PH_HDR) || (fetch_slot.phase == PH_DATA));

	// modulo 65536 byte sum, cleared during the preamble
	always_ff @(posedge clk or negedge c_done) begin
		if (!c_done) begin
			sum <= '0;
		end else if (fetch_slot.phase == PH_PRE) begin
			sum <= '0;
		end else if (sum_en) begin
			sum <= sum + {8'h00, fetch_byte};
		end
	end

	// trailer carries the finished sum, low byte first
	// sum holds still through the trailer
	always_comb begin
		if (fetch_slot.phase == PH_TRL) begin
			if (fetch_slot.pos == POS_W'(0)) begin
				out_byte = sum[7:0];
			end else if (fetch_slot.pos == POS_W'(1)) begin
				out_byte = sum[15:8];
			end else begin
				out_byte = '0;
			end
		end else begin
			out_byte = fetch_byte;
		end
	end

	// output register stage
	always_ff @(posedge clk or negedge c_done) begin
		if (!c_done) begin
			rxd <= '0;
			rxen <= 1'b0;
			pac_stp <= 1'b0;
			ovp <= 1'b0;
		end else begin
			// idle cycles put zero on the bus
			rxd <= fetch_slot.en ? out_byte : '0;
			rxen <= fetch_slot.en;
			pac_stp <= pkt_start;
			// ovp flags the frame-sync packet only
			ovp <= pkt_start && (fetch_slot.pkt_idx == '0);
		end
	end

endmodule

// ==== rtl/byte_fetch.sv ====
module byte_fetch #(
	parameter int RAM_ADDR_WIDTH = 10,
	parameter int FIX_OFFSET = 7,
	parameter fgen_pkg::byte_t FIX_VALUE = 8'h01
) (
	input logic clk,
	input logic c_done,
	input fgen_pkg::slot_t seq_slot,
	output logic [RAM_ADDR_WIDTH-1:0] ram_ra,
	input fgen_pkg::byte_t ram_rd,
	output fgen_pkg::slot_t fetch_slot,
	output fgen_pkg::byte_t fetch_byte
);
	import fgen_pkg::*;

	logic frame_start;
	logic fix_hit;

	// first preamble byte of the frame-sync packet
	assign frame_start = seq_slot.en && (seq_slot.phase == PH_PRE) &&
		(seq_slot.pos == '0) && (seq_slot.kind == KIND_SYNC);

	// address restarts each frame and steps once per read byte
	// the RAM samples the old address on the same edge
	always_ff @(posedge clk or negedge c_done) begin
		if (!c_done) begin
			ram_ra <= '0;
		end else if (frame_start) begin
			ram_ra <= '0;
		end else if (seq_slot.read) begin
			ram_ra <= ram_ra + 1'b1;
		end
	end

	// slot delayed by one stage to meet the RAM read data
	always_ff @(posedge clk or negedge c_done) begin
		if (!c_done) begin
			fetch_slot <= '0;
		end else begin
			fetch_slot <= seq_slot;
		end
	end

	// panel-width high byte inside packet 1
	assign fix_hit = (fetch_slot.pkt_idx == PKT_IDX_W'(1)) &&
		(fetch_slot.pos == POS_W'(FIX_OFFSET));

	always_comb begin
		fetch_byte = '0;
		case (fetch_slot.phase)
			PH_PRE: begin
				// 0x55 run closed by the start delimiter
				if (fetch_slot.pos == POS_W'(PREAMBLE_LEN - 1)) begin
					fetch_byte = SFD_BYTE;
				end else begin
					fetch_byte = PREAMBLE_BYTE;
				end
			end
			PH_HDR: begin
				// packet index low byte, then its upper bits
				if (fetch_slot.pos == POS_W'(0)) begin
					fetch_byte = fetch_slot.pkt_idx[7:0];
				end else if (fetch_slot.pos == POS_W'(1)) begin
					fetch_byte = byte_t'(fetch_slot.pkt_idx[PKT_IDX_W-1:8]);
				end else begin
					fetch_byte = '0;
				end
			end
			PH_DATA: begin
				// fixed byte wins over the RAM byte it replaces
				if (fix_hit) begin
					fetch_byte = FIX_VALUE;
				end else if (fetch_slot.read) begin
					fetch_byte = ram_rd;
				end else begin
					// sync data and video padding
					fetch_byte = '0;
				end
			end
			// trailer is filled in by the checksum stage
			default: fetch_byte = '0;
		endcase
	end

endmodule

// ==== rtl/pkt_sequencer.sv ====
module pkt_sequencer #(
	parameter int PKT_IFG = 4,
	parameter int FRAME_IFG = 40,
	parameter int CMD_PKTS = 2,
	parameter int VIDEO_PKTS = 3,
	parameter int CMD_LEN = 16,
	parameter int VIDEO_LEN = 24,
	parameter int LINE_LEN = 20
) (
	input logic clk,
	input logic c_done,
	output fgen_pkg::slot_t seq_slot
);
	import fgen_pkg::*;

	// index of the last video packet, the index wraps after it
	localparam int LAST_PKT = CMD_PKTS + VIDEO_PKTS;
	localparam int GAP_MAX = (FRAME_IFG > PKT_IFG) ? FRAME_IFG : PKT_IFG;
	localparam int IDLE_W = $clog2(GAP_MAX + 1);

	phase_t state;
	phase_t state_next;
	logic [IDLE_W-1:0] idle_cnt;
	logic [IDLE_W-1:0] gap_len;
	logic gap_done;
	logic [POS_W-1:0] pos;
	logic [POS_W-1:0] data_len;
	logic last_byte;
	logic [PKT_IDX_W-1:0] pkt_idx;
	pkt_kind_t kind;
	slot_t slot_next;

	// packet 0 syncs the frame, then commands, then video lines
	always_comb begin
		if (pkt_idx == '0) begin
			kind = KIND_SYNC;
		end else if (pkt_idx <= PKT_IDX_W'(CMD_PKTS)) begin
			kind = KIND_CMD;
		end else begin
			kind = KIND_VIDEO;
		end
	end

	// sync packets carry as many bytes as a command packet
	assign data_len = (kind == KIND_VIDEO) ? POS_W'(VIDEO_LEN) : POS_W'(CMD_LEN);

	// long gap only in front of the frame-sync packet
	assign gap_len = (pkt_idx == '0) ? IDLE_W'(FRAME_IFG) : IDLE_W'(PKT_IFG);
	assign gap_done = (idle_cnt == gap_len - 1'b1);

	// last byte of the current phase
	always_comb begin
		case (state)
			PH_PRE: last_byte = (pos == POS_W'(PREAMBLE_LEN - 1));
			PH_HDR: last_byte = (pos == POS_W'(HEADER_LEN - 1));
			PH_DATA: last_byte = (pos == data_len - 1'b1);
			PH_TRL: last_byte = (pos == POS_W'(TRAILER_LEN - 1));
			default: last_byte = 1'b0;
		endcase
	end

	// phase order is fixed, each phase ends on its last byte
	always_comb begin
		state_next = state;
		case (state)
			PH_IDLE: if (gap_done) state_next = PH_PRE;
			PH_PRE: if (last_byte) state_next = PH_HDR;
			PH_HDR: if (last_byte) state_next = PH_DATA;
			PH_DATA: if (last_byte) state_next = PH_TRL;
			PH_TRL: if (last_byte) state_next = PH_IDLE;
			default: state_next = PH_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge c_done) begin
		if (!c_done) begin
			state <= PH_IDLE;
			idle_cnt <= '0;
			pos <= '0;
			pkt_idx <= '0;
		end else begin
			state <= state_next;
			// idle counter runs only while waiting for the gap
			if (state == PH_IDLE && !gap_done) begin
				idle_cnt <= idle_cnt + 1'b1;
			end else begin
				idle_cnt <= '0;
			end
			// one position counter, restarted at every phase
			if (state != PH_IDLE && !last_byte) begin
				pos <= pos + 1'b1;
			end else begin
				pos <= '0;
			end
			// next packet after the last trailer byte
			if (state == PH_TRL && last_byte) begin
				if (pkt_idx == PKT_IDX_W'(LAST_PKT)) begin
					pkt_idx <= '0;
				end else begin
					pkt_idx <= pkt_idx + 1'b1;
				end
			end
		end
	end

	// describe the byte this state produces
	always_comb begin
		slot_next.en = (state != PH_IDLE);
		slot_next.phase = state;
		slot_next.kind = kind;
		slot_next.pkt_idx = pkt_idx;
		slot_next.pos = pos;
		// video bytes past the line are zero padding
		slot_next.read = (state == PH_DATA) && (kind != KIND_SYNC) &&
			((kind == KIND_CMD) || (pos < POS_W'(LINE_LEN)));
	end

	always_ff @(posedge clk or negedge c_done) begin
		if (!c_done) begin
			seq_slot <= '0;
		end else begin
			seq_slot <= slot_next;
		end
	end

endmodule

// ==== rtl/fgen_pkg.sv ====
package fgen_pkg;

	// one byte on the receive stream
	typedef logic [7:0] byte_t;

	// packet index and byte position widths
	localparam int PKT_IDX_W = 11;
	localparam int POS_W = 12;

	// framing bytes
	localparam byte_t PREAMBLE_BYTE = 8'h55;
	localparam byte_t SFD_BYTE = 8'hd5;

	// fixed phase lengths in bytes
	localparam int PREAMBLE_LEN = 4;
	localparam int HEADER_LEN = 4;
	localparam int TRAILER_LEN = 4;

	// packet class, taken from the packet index
	typedef enum logic [1:0] {
		KIND_SYNC  = 2'd0,
		KIND_CMD   = 2'd1,
		KIND_VIDEO = 2'd2
	} pkt_kind_t;

	// where a byte sits inside a packet
	typedef enum logic [2:0] {
		PH_IDLE = 3'd0,
		PH_PRE  = 3'd1,
		PH_HDR  = 3'd2,
		PH_DATA = 3'd3,
		PH_TRL  = 3'd4
	} phase_t;

	// one stream cycle as it moves down the pipeline
	typedef struct packed {
		// byte present on this cycle
		logic en;
		phase_t phase;
		pkt_kind_t kind;
		logic [PKT_IDX_W-1:0] pkt_idx;
		// byte offset within the current phase
		logic [POS_W-1:0] pos;
		// data byte is taken from the external RAM
		logic read;
	} slot_t;

endpackage
